// File: design/spi_cfg_pkg.sv
// Fixed 8-bit data path and 2-bit word address; SCK half-period below 3 clk cycles is not supported
// ---------------------------------------------------------------------------
// Build-wide sizing for the SPI controller
// ---------------------------------------------------------------------------
package spi_cfg_pkg;

  // Width of one SPI byte
  // Also the Wishbone data bus width
  localparam int DATA_W = 8;

  // Word address width on the Wishbone side
  // Four registers, one word each
  localparam int ADDR_W = 2;

  // clk cycles per SCK phase, low or high
  // One full SCK period is twice this
  localparam int HALF_PERIOD_DEFAULT = 4;

  // Lower bound for the half-period
  // Two cycles go to the MISO synchroniser, one to the sample
  localparam int HALF_PERIOD_MIN = 3;

  // A whole byte transfer then takes 16 half-periods
  // With the default that is 64 clk cycles

endpackage

// File: design/spi_reg_pkg.sv
// Register map is word addressed; unused bits read as zero and writes to read-only registers are ignored
// ---------------------------------------------------------------------------
// Register map of the SPI controller
// ---------------------------------------------------------------------------
package spi_reg_pkg;

  // Register addresses
  localparam logic [spi_cfg_pkg::ADDR_W-1:0] ADDR_CTRL   = 'd0;
  localparam logic [spi_cfg_pkg::ADDR_W-1:0] ADDR_STATUS = 'd1;
  localparam logic [spi_cfg_pkg::ADDR_W-1:0] ADDR_TXDATA = 'd2;
  localparam logic [spi_cfg_pkg::ADDR_W-1:0] ADDR_RXDATA = 'd3;

  // CTRL bits
  // Enable holds chip select active while set
  localparam int CTRL_ENABLE  = 0;
  // Write one to clear the overrun flag
  // Never stored, reads back as zero
  localparam int CTRL_CLR_OVR = 1;

  // STATUS bits, all read only
  // Engine idle and able to take a new byte
  localparam int STAT_READY    = 0;
  // Unread byte waiting in RXDATA
  localparam int STAT_RX_VALID = 1;
  // Byte lost to a newer one before it was read
  localparam int STAT_OVERRUN  = 2;

  // TXDATA is write only and reads as zero
  // RXDATA read also clears rx_valid

endpackage

// File: design/spi_reg_decode.sv
// Wishbone classic slave only; master must hold the cycle until ack, two clk cycles per access, no wait states or errors
`timescale 1ns/1ns

module spi_reg_decode (
  input  logic                           clk,
  input  logic                           reset_n,
  // Wishbone classic slave
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [spi_cfg_pkg::ADDR_W-1:0] wb_adr,
  input  logic [spi_cfg_pkg::DATA_W-1:0] wb_dat_w,
  output logic [spi_cfg_pkg::DATA_W-1:0] wb_dat_r,
  output logic                           wb_ack,
  // Shift engine side
  output logic                           ss_enable,
  output logic [spi_cfg_pkg::DATA_W-1:0] tx_data,
  output logic                           start,
  input  logic                           ready,
  // Receive buffer side
  input  logic [spi_cfg_pkg::DATA_W-1:0] rx_byte,
  input  logic                           rx_valid,
  input  logic                           overrun,
  output logic                           rx_read,
  output logic                           clr_ovr
);

  logic ack_q;
  logic enable_q;
  logic acc_wr;
  logic acc_rd;

  // ---------------------------------------------------------------------------
  // Bus handshake
  // ---------------------------------------------------------------------------
  // Ack one cycle after a request and drop for at least one cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc & wb_stb & ~ack_q;
    end
  end

  assign wb_ack = ack_q;

  // Access qualifiers are valid in the ack cycle only
  assign acc_wr = ack_q & wb_we;
  assign acc_rd = ack_q & ~wb_we;

  // ---------------------------------------------------------------------------
  // CTRL register and strobes
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      enable_q <= 1'b0;
    end else if (acc_wr && (wb_adr == spi_reg_pkg::ADDR_CTRL)) begin
      enable_q <= wb_dat_w[spi_reg_pkg::CTRL_ENABLE];
    end
  end

  assign ss_enable = enable_q;

  // Engine loads the bus data on the same edge as the ack
  assign tx_data = wb_dat_w;
  assign start   = acc_wr && (wb_adr == spi_reg_pkg::ADDR_TXDATA);
  assign clr_ovr = acc_wr && (wb_adr == spi_reg_pkg::ADDR_CTRL)
                   && wb_dat_w[spi_reg_pkg::CTRL_CLR_OVR];
  assign rx_read = acc_rd && (wb_adr == spi_reg_pkg::ADDR_RXDATA);

  // ---------------------------------------------------------------------------
  // Read mux
  // ---------------------------------------------------------------------------
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      spi_reg_pkg::ADDR_CTRL: begin
        wb_dat_r[spi_reg_pkg::CTRL_ENABLE] = enable_q;
      end
      spi_reg_pkg::ADDR_STATUS: begin
        wb_dat_r[spi_reg_pkg::STAT_READY]    = ready;
        wb_dat_r[spi_reg_pkg::STAT_RX_VALID] = rx_valid;
        wb_dat_r[spi_reg_pkg::STAT_OVERRUN]  = overrun;
      end
      spi_reg_pkg::ADDR_RXDATA: wb_dat_r = rx_byte;
      // TXDATA is write only
      default: wb_dat_r = '0;
    endcase
  end

  // Strobes decode the live request, so it must stay put through the ack
  a_ack_held: assert property (@(posedge clk) disable iff (!reset_n)
    wb_ack |-> wb_cyc && wb_stb && $stable(wb_we) && $stable(wb_adr));

endmodule

// File: design/spi_shift_engine.sv
// SPI mode 0 only, MSB first, one slave select; half_period of at least 3 clk cycles, start ignored while busy
`timescale 1ns/1ns

module spi_shift_engine #(
  parameter int half_period = spi_cfg_pkg::HALF_PERIOD_DEFAULT
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           ss_enable,
  input  logic                           start,
  input  logic [spi_cfg_pkg::DATA_W-1:0] tx_data,
  output logic                           ready,
  output logic [spi_cfg_pkg::DATA_W-1:0] rx_data,
  output logic                           rx_done,
  output logic                           spi_ss,
  output logic                           spi_sck,
  output logic                           spi_mosi,
  input  logic                           spi_miso
);

  localparam int DW    = spi_cfg_pkg::DATA_W;
  localparam int PH_W  = (half_period > 1) ? $clog2(half_period) : 1;
  localparam int BIT_W = $clog2(DW);

  // Synchroniser plus sample need three cycles in each phase
  if (half_period < spi_cfg_pkg::HALF_PERIOD_MIN) begin : g_half_period_check
    $error("spi_shift_engine: half_period below HALF_PERIOD_MIN");
  end

  // ---------------------------------------------------------------------------
  // State and next-state values
  // ---------------------------------------------------------------------------
  logic             ss_q;
  logic             sck_q;
  logic             sck_new;
  logic [DW-1:0]    shreg_q;
  logic [DW-1:0]    shreg_new;
  logic [PH_W-1:0]  ph_ctr_q;
  logic [PH_W-1:0]  ph_ctr_new;
  logic [BIT_W-1:0] bit_ctr_q;
  logic [BIT_W-1:0] bit_ctr_new;
  logic             ready_q;
  logic             ready_new;
  logic             done_q;
  logic             done_new;
  logic             miso_meta;
  logic             miso_sync;
  logic             phase_end;

  assign spi_ss   = ss_q;
  assign spi_sck  = sck_q;
  // MSB always on the line
  assign spi_mosi = shreg_q[DW-1];
  assign ready    = ready_q;
  assign rx_done  = done_q;
  assign rx_data  = shreg_q;

  // Last clk cycle of the current SCK phase
  assign phase_end = (ph_ctr_q == PH_W'(half_period - 1));

  // ---------------------------------------------------------------------------
  // Register update
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ss_q      <= 1'b1;
      sck_q     <= 1'b0;
      shreg_q   <= '0;
      ph_ctr_q  <= '0;
      bit_ctr_q <= '0;
      ready_q   <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      // Chip select follows the enable, active low
      ss_q      <= ~ss_enable;
      sck_q     <= sck_new;
      shreg_q   <= shreg_new;
      ph_ctr_q  <= ph_ctr_new;
      bit_ctr_q <= bit_ctr_new;
      ready_q   <= ready_new;
      done_q    <= done_new;
    end
  end

  // Two-stage MISO synchroniser
  always_ff @(posedge clk) begin
    miso_meta <= spi_miso;
    miso_sync <= miso_meta;
  end

  // ---------------------------------------------------------------------------
  // Transfer control
  // ---------------------------------------------------------------------------
  always_comb begin
    sck_new     = sck_q;
    shreg_new   = shreg_q;
    ph_ctr_new  = ph_ctr_q;
    bit_ctr_new = bit_ctr_q;
    ready_new   = ready_q;
    done_new    = 1'b0;
    if (ready_q) begin
      // Idle, first bit goes out together with the load
      if (start) begin
        shreg_new   = tx_data;
        sck_new     = 1'b0;
        ph_ctr_new  = '0;
        bit_ctr_new = '0;
        ready_new   = 1'b0;
      end
    end else if (phase_end) begin
      ph_ctr_new = '0;
      sck_new    = ~sck_q;
      // End of high phase: sample MISO, SCK falls, next bit shifts out
      if (sck_q) begin
        shreg_new   = {shreg_q[DW-2:0], miso_sync};
        bit_ctr_new = bit_ctr_q + 1'b1;
        if (bit_ctr_q == BIT_W'(DW - 1)) begin
          ready_new = 1'b1;
          done_new  = 1'b1;
        end
      end
    end else begin
      ph_ctr_new = ph_ctr_q + 1'b1;
    end
  end

  // SCK parks low between transfers
  a_sck_idle_low: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> !spi_sck);

endmodule

// File: design/spi_rx_buffer.sv
// Single-byte buffer; a new byte always overwrites an unread one and sets overrun
`timescale 1ns/1ns

module spi_rx_buffer (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic [spi_cfg_pkg::DATA_W-1:0] rx_data,
  input  logic                           rx_done,
  input  logic                           rx_read,
  input  logic                           clr_ovr,
  output logic [spi_cfg_pkg::DATA_W-1:0] rx_byte,
  output logic                           rx_valid,
  output logic                           overrun
);

  logic [spi_cfg_pkg::DATA_W-1:0] byte_q;
  logic                           valid_q;
  logic                           ovr_q;

  assign rx_byte  = byte_q;
  assign rx_valid = valid_q;
  assign overrun  = ovr_q;

  // Payload capture
  always_ff @(posedge clk) begin
    if (rx_done) begin
      byte_q <= rx_data;
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
      ovr_q   <= 1'b0;
    end else begin
      // Capture beats a read in the same cycle
      if (rx_done) begin
        valid_q <= 1'b1;
      end else if (rx_read) begin
        valid_q <= 1'b0;
      end
      // Old byte lost only when nobody is reading it right now
      if (rx_done && valid_q && !rx_read) begin
        ovr_q <= 1'b1;
      end else if (clr_ovr) begin
        ovr_q <= 1'b0;
      end
    end
  end

  // A held rx_done would count as a second byte and set overrun
  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    rx_done |=> !rx_done);

endmodule

// File: design/spi_ctrl_top.sv
// Byte SPI master, mode 0, behind a Wishbone classic slave; half_period sets SCK and must be 3 or more
`timescale 1ns/1ns

module spi_ctrl_top #(
  parameter int half_period = spi_cfg_pkg::HALF_PERIOD_DEFAULT
) (
  input  logic                           clk,
  input  logic                           reset_n,
  // Wishbone classic
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [spi_cfg_pkg::ADDR_W-1:0] wb_adr,
  input  logic [spi_cfg_pkg::DATA_W-1:0] wb_dat_w,
  output logic [spi_cfg_pkg::DATA_W-1:0] wb_dat_r,
  output logic                           wb_ack,
  // SPI pins
  output logic                           spi_ss,
  output logic                           spi_sck,
  output logic                           spi_mosi,
  input  logic                           spi_miso
);

  // ---------------------------------------------------------------------------
  // Internal nets
  // ---------------------------------------------------------------------------
  logic                           ss_enable;
  logic [spi_cfg_pkg::DATA_W-1:0] tx_data;
  logic                           start;
  logic                           ready;
  logic [spi_cfg_pkg::DATA_W-1:0] rx_data;
  logic                           rx_done;
  logic                           rx_read;
  logic                           clr_ovr;
  logic [spi_cfg_pkg::DATA_W-1:0] rx_byte;
  logic                           rx_valid;
  logic                           overrun;

  // Register decode and bus port
  spi_reg_decode i_decode (
    .clk, .reset_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .ss_enable, .tx_data, .start, .ready,
    .rx_byte, .rx_valid, .overrun, .rx_read, .clr_ovr
  );

  // SCK timing comes from the top parameter
  spi_shift_engine #(.half_period(half_period)) i_engine (
    .clk, .reset_n,
    .ss_enable, .start, .tx_data, .ready, .rx_data, .rx_done,
    .spi_ss, .spi_sck, .spi_mosi, .spi_miso
  );

  spi_rx_buffer i_rx_buffer (
    .clk, .reset_n,
    .rx_data, .rx_done, .rx_read, .clr_ovr,
    .rx_byte, .rx_valid, .overrun
  );

endmodule

// File: bench/spi_slave_model.sv
// Simulation-only mode 0 SPI slave; answers 0xA5 first, then the complement of the byte before
`timescale 1ns/1ns

module spi_slave_model (
  input  logic                           spi_ss,
  input  logic                           spi_sck,
  input  logic                           spi_mosi,
  output logic                           spi_miso,
  output logic [spi_cfg_pkg::DATA_W-1:0] last_rx,
  output int                             rx_count
);

  localparam int DW = spi_cfg_pkg::DATA_W;

  logic [DW-1:0] tx_sr;
  logic [DW-1:0] rx_sr;
  logic [DW-1:0] rx_next;
  int            bit_cnt;

  // First reply preloaded so bit 7 is on MISO before the first edge
  initial begin
    tx_sr    = 8'hA5;
    rx_sr    = '0;
    bit_cnt  = 0;
    last_rx  = '0;
    rx_count = 0;
  end

  assign spi_miso = tx_sr[DW-1];
  assign rx_next  = {rx_sr[DW-2:0], spi_mosi};

  // Mode 0 sample on the rising edge
  always @(posedge spi_sck) begin
    if (spi_ss == 1'b0) begin
      if (bit_cnt == DW - 1) begin
        last_rx  <= rx_next;
        rx_count <= rx_count + 1;
        bit_cnt  <= 0;
      end else begin
        rx_sr   <= rx_next;
        bit_cnt <= bit_cnt + 1;
      end
    end
  end

  // Falling edge shifts, or loads the next reply after a full byte
  always @(negedge spi_sck) begin
    if (spi_ss == 1'b0) begin
      if (bit_cnt == 0) begin
        tx_sr <= ~last_rx;
      end else begin
        tx_sr <= {tx_sr[DW-2:0], 1'b0};
      end
    end
  end

endmodule

// File: bench/tb_spi_ctrl.sv
// Testbench for the default half-period only; stops at the first mismatch or after a fixed cycle limit
`timescale 1ns/1ns

module tb_spi_ctrl;

  localparam int DW = spi_cfg_pkg::DATA_W;
  localparam int AW = spi_cfg_pkg::ADDR_W;
  // SCK time of one byte plus start and poll skew
  localparam int XFER_CYCLES    = 16 * spi_cfg_pkg::HALF_PERIOD_DEFAULT + 6;
  localparam int N_XFER_MAX     = 30;
  // Generous polling margin per byte plus register tests and reset
  localparam int TIMEOUT_CYCLES = 2 * N_XFER_MAX * XFER_CYCLES + 800;
  localparam int N_RANDOM       = 20;

  logic          clk;
  logic          reset_n;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  logic [AW-1:0] wb_adr;
  logic [DW-1:0] wb_dat_w;
  logic [DW-1:0] wb_dat_r;
  logic          wb_ack;
  logic          spi_ss;
  logic          spi_sck;
  logic          spi_mosi;
  logic          spi_miso;
  logic [DW-1:0] slave_last_rx;
  int            slave_rx_count;

  int            seed = 5;
  int            cycle_count = 0;
  int            seen_count = 0;
  int            n;
  int            count_before;
  logic          have_prev;
  logic [DW-1:0] prev_tx;
  logic [DW-1:0] rd;
  logic [DW-1:0] tx_byte;
  logic [DW-1:0] first_byte;
  logic [DW-1:0] exp_rx;
  // Bytes the slave should see on MOSI, oldest first
  logic [DW-1:0] mosi_exp_q [$];

  spi_ctrl_top i_dut (
    .clk, .reset_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .spi_ss, .spi_sck, .spi_mosi, .spi_miso
  );

  spi_slave_model i_slave (
    .spi_ss, .spi_sck, .spi_mosi, .spi_miso,
    .last_rx(slave_last_rx), .rx_count(slave_rx_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ---------------------------------------------------------------------------
  // Reference model, checker, bus access
  // ---------------------------------------------------------------------------
  // Slave reply is A5 before any byte and else the complement of the previous one
  function automatic logic [DW-1:0] expected_rx(input logic had_prev, input logic [DW-1:0] prev);
    if (had_prev) begin
      return ~prev;
    end else begin
      return 8'hA5;
    end
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Check %s failed", test_name);
    end
  endtask

  // Request held through the edge that ends the ack cycle
  task automatic bus_write(input logic [AW-1:0] adr, input logic [DW-1:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    do begin
      @(negedge clk);
    end while (!wb_ack);
    @(negedge clk);
    // Ack lasts exactly one cycle
    check_value("write_ack_single", 0, wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [AW-1:0] adr, output logic [DW-1:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do begin
      @(negedge clk);
    end while (!wb_ack);
    // Data valid while ack is high
    data = wb_dat_r;
    @(negedge clk);
    check_value("read_ack_single", 0, wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wait_ready();
    logic [DW-1:0] status;
    do begin
      bus_read(spi_reg_pkg::ADDR_STATUS, status);
    end while (!status[spi_reg_pkg::STAT_READY]);
  endtask

  // Sends one byte and returns the RX byte the reference predicts
  task automatic send_byte(input logic [DW-1:0] data, output logic [DW-1:0] exp);
    exp = expected_rx(have_prev, prev_tx);
    mosi_exp_q.push_back(data);
    bus_write(spi_reg_pkg::ADDR_TXDATA, data);
    wait_ready();
    have_prev = 1'b1;
    prev_tx   = data;
  endtask

  // Every byte the slave counts must be the next one sent
  always @(negedge clk) begin
    if (slave_rx_count != seen_count) begin
      seen_count = slave_rx_count;
      if (mosi_exp_q.size() == 0) begin
        $display("The slave received a byte that the testbench never sent");
        $display("*** FAILED ***");
        $fatal(1, "Unexpected SPI transfer");
      end else begin
        check_value("slave_mosi", mosi_exp_q.pop_front(), slave_last_rx);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  initial begin
    reset_n   = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    have_prev = 1'b0;
    prev_tx   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset state
    bus_read(spi_reg_pkg::ADDR_STATUS, rd);
    check_value("reset_status", 1 << spi_reg_pkg::STAT_READY, rd);
    bus_read(spi_reg_pkg::ADDR_CTRL, rd);
    check_value("reset_ctrl", 0, rd);
    check_value("reset_ss", 1, spi_ss);
    check_value("reset_sck", 0, spi_sck);
    check_value("reset_mosi", 0, spi_mosi);
    check_value("reset_ack", 0, wb_ack);

    // Chip select on and off again
    // Spi_ss follows the register one cycle later
    bus_write(spi_reg_pkg::ADDR_CTRL, 1 << spi_reg_pkg::CTRL_ENABLE);
    bus_read(spi_reg_pkg::ADDR_CTRL, rd);
    check_value("enable_ctrl", 1, rd);
    check_value("enable_ss", 0, spi_ss);
    bus_write(spi_reg_pkg::ADDR_CTRL, 0);
    bus_read(spi_reg_pkg::ADDR_CTRL, rd);
    check_value("disable_ctrl", 0, rd);
    check_value("disable_ss", 1, spi_ss);
    bus_write(spi_reg_pkg::ADDR_CTRL, 1 << spi_reg_pkg::CTRL_ENABLE);

    // Single transfer
    send_byte(8'h3C, exp_rx);
    check_value("single_last_rx", 8'h3C, slave_last_rx);
    bus_read(spi_reg_pkg::ADDR_RXDATA, rd);
    check_value("single_rx", exp_rx, rd);
    bus_read(spi_reg_pkg::ADDR_STATUS, rd);
    check_value("single_rx_valid", 0, rd[spi_reg_pkg::STAT_RX_VALID]);

    // Random stream with an RX read after each byte
    for (n = 0; n < N_RANDOM; n++) begin
      tx_byte = DW'($random(seed));
      send_byte(tx_byte, exp_rx);
      check_value("stream_last_rx", tx_byte, slave_last_rx);
      bus_read(spi_reg_pkg::ADDR_RXDATA, rd);
      check_value("stream_rx", exp_rx, rd);
    end

    // Overrun from two bytes without a read
    send_byte(DW'($random(seed)), exp_rx);
    send_byte(DW'($random(seed)), exp_rx);
    bus_read(spi_reg_pkg::ADDR_STATUS, rd);
    check_value("overrun_status", (1 << spi_reg_pkg::STAT_READY)
                | (1 << spi_reg_pkg::STAT_RX_VALID) | (1 << spi_reg_pkg::STAT_OVERRUN), rd);
    bus_write(spi_reg_pkg::ADDR_CTRL,
              (1 << spi_reg_pkg::CTRL_ENABLE) | (1 << spi_reg_pkg::CTRL_CLR_OVR));
    bus_read(spi_reg_pkg::ADDR_STATUS, rd);
    check_value("overrun_cleared",
                (1 << spi_reg_pkg::STAT_READY) | (1 << spi_reg_pkg::STAT_RX_VALID), rd);
    // Clear bit is not stored
    bus_read(spi_reg_pkg::ADDR_CTRL, rd);
    check_value("overrun_ctrl", 1, rd);
    check_value("overrun_ss", 0, spi_ss);
    bus_read(spi_reg_pkg::ADDR_RXDATA, rd);
    check_value("overrun_rx", exp_rx, rd);

    // Second TXDATA write lands while the engine is busy
    count_before = slave_rx_count;
    first_byte   = DW'($random(seed));
    tx_byte      = DW'($random(seed));
    exp_rx       = expected_rx(have_prev, prev_tx);
    mosi_exp_q.push_back(first_byte);
    bus_write(spi_reg_pkg::ADDR_TXDATA, first_byte);
    bus_write(spi_reg_pkg::ADDR_TXDATA, tx_byte);
    wait_ready();
    have_prev = 1'b1;
    prev_tx   = first_byte;
    check_value("busy_count", count_before + 1, slave_rx_count);
    check_value("busy_last_rx", first_byte, slave_last_rx);
    bus_read(spi_reg_pkg::ADDR_RXDATA, rd);
    check_value("busy_rx", exp_rx, rd);

    // Nothing sent that the slave missed
    check_value("mosi_all_seen", 0, mosi_exp_q.size());
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
design/spi_cfg_pkg.sv
design/spi_reg_pkg.sv
design/spi_reg_decode.sv
design/spi_shift_engine.sv
design/spi_rx_buffer.sv
design/spi_ctrl_top.sv
bench/spi_slave_model.sv
bench/tb_spi_ctrl.sv

// File: Bender.yml
package:
  name: spi_ctrl

sources:
  - design/spi_cfg_pkg.sv
  - design/spi_reg_pkg.sv
  - design/spi_reg_decode.sv
  - design/spi_shift_engine.sv
  - design/spi_rx_buffer.sv
  - design/spi_ctrl_top.sv
  - target: test
    files:
      - bench/spi_slave_model.sv
      - bench/tb_spi_ctrl.sv
